//--- design/soc_consts.svh
/*
 * Bus and main memory geometry shared by RTL and testbench.
 * Address bits above the memory size are ignored, so the memory aliases.
 */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus word
`define SOC_DATA_W     32
`define SOC_STRB_W     4
`define SOC_ADDR_W     32

// Main memory
`define SOC_PAGES      8
`define SOC_PAGE_WORDS 1024

// Derived index widths
`define SOC_OFS_W      ($clog2(`SOC_STRB_W))
`define SOC_IDX_W      ($clog2(`SOC_PAGE_WORDS))
`define SOC_PSEL_W     ($clog2(`SOC_PAGES))

// Bus cycles from grant to ack
`define SOC_ACK_LAT    2

`endif

//--- design/soc_pkg.sv
/*
 * Shared bus types. The byte view of a word is what the pages write
 * under the strobes, byte 0 being bits 7:0.
 */
`default_nettype none

`include "soc_consts.svh"

package soc_pkg;

  typedef union packed {
    logic [`SOC_DATA_W-1:0]       word;
    logic [`SOC_STRB_W-1:0][7:0]  bytes;
  } bus_word_u;

  // Bus owner
  typedef enum logic {
    MASTER_MMU = 1'b0,
    MASTER_DMA = 1'b1
  } master_id_e;

endpackage

`default_nettype wire

//--- design/bus_arbiter.sv
/*
 * Fixed-priority arbiter for the mmu and dma masters, mmu first.
 * One access in flight. A master holds cyc and all fields until ack.
 * At the ack edge the grant passes straight to the other master if it waits.
 */
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module bus_arbiter (
  input  wire                        clk_i,
  input  wire                        rst_i,
  // mmu master
  input  wire                        m_mmu_cyc_i,
  input  wire                        m_mmu_we_i,
  input  wire [`SOC_STRB_W-1:0]      m_mmu_strb_i,
  input  wire [`SOC_ADDR_W-1:0]      m_mmu_addr_i,
  input  wire [`SOC_DATA_W-1:0]      m_mmu_wdata_i,
  output logic                       m_mmu_ack_o,
  output logic [`SOC_DATA_W-1:0]     m_mmu_rdata_o,
  // dma master
  input  wire                        m_dma_cyc_i,
  input  wire                        m_dma_we_i,
  input  wire [`SOC_STRB_W-1:0]      m_dma_strb_i,
  input  wire [`SOC_ADDR_W-1:0]      m_dma_addr_i,
  input  wire [`SOC_DATA_W-1:0]      m_dma_wdata_i,
  output logic                       m_dma_ack_o,
  output logic [`SOC_DATA_W-1:0]     m_dma_rdata_o,
  // Granted request
  output logic                       req_valid_o,
  output logic                       req_we_o,
  output logic [`SOC_STRB_W-1:0]     req_strb_o,
  output logic [`SOC_ADDR_W-1:0]     req_addr_o,
  output soc_pkg::bus_word_u         req_wdata_o,
  // Return path
  input  wire                        bus_ack_i,
  input  wire soc_pkg::bus_word_u    bus_rdata_i
);

  import soc_pkg::*;

  master_id_e owner_q;
  logic       busy_q;
  logic       grant_mmu;
  logic       grant_dma;

  ////////////////////////////////////////
  // Grant
  ////////////////////////////////////////

  // The owner still shows cyc during its ack cycle, so it is skipped there
  always_comb begin
    grant_mmu = 1'b0;
    grant_dma = 1'b0;
    if (!busy_q) begin
      grant_mmu = m_mmu_cyc_i;
      grant_dma = m_dma_cyc_i & ~m_mmu_cyc_i;
    end else if (bus_ack_i) begin
      grant_mmu = (owner_q == MASTER_DMA) & m_mmu_cyc_i;
      grant_dma = (owner_q == MASTER_MMU) & m_dma_cyc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q      <= 1'b0;
      owner_q     <= MASTER_MMU;
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= grant_mmu | grant_dma;
      if (grant_mmu) begin
        busy_q  <= 1'b1;
        owner_q <= MASTER_MMU;
      end else if (grant_dma) begin
        busy_q  <= 1'b1;
        owner_q <= MASTER_DMA;
      end else if (bus_ack_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Request and return steering
  ////////////////////////////////////////

  // Fields stay stable under cyc, so no capture needed here
  always_comb begin
    if (owner_q == MASTER_MMU) begin
      req_we_o         = m_mmu_we_i;
      req_strb_o       = m_mmu_strb_i;
      req_addr_o       = m_mmu_addr_i;
      req_wdata_o.word = m_mmu_wdata_i;
    end else begin
      req_we_o         = m_dma_we_i;
      req_strb_o       = m_dma_strb_i;
      req_addr_o       = m_dma_addr_i;
      req_wdata_o.word = m_dma_wdata_i;
    end
  end

  assign m_mmu_ack_o   = bus_ack_i & busy_q & (owner_q == MASTER_MMU);
  assign m_dma_ack_o   = bus_ack_i & busy_q & (owner_q == MASTER_DMA);
  assign m_mmu_rdata_o = (owner_q == MASTER_MMU) ? bus_rdata_i.word : '0;
  assign m_dma_rdata_o = (owner_q == MASTER_DMA) ? bus_rdata_i.word : '0;

endmodule

`default_nettype wire

//--- design/page_select.sv
/*
 * Registers the granted request and splits the word address into page
 * and word index. Address bits above the memory size are dropped.
 */
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module page_select (
  input  wire                                   clk_i,
  input  wire                                   rst_i,
  input  wire                                   req_valid_i,
  input  wire                                   req_we_i,
  input  wire [`SOC_STRB_W-1:0]                 req_strb_i,
  input  wire [`SOC_ADDR_W-1:0]                 req_addr_i,
  input  wire soc_pkg::bus_word_u               req_wdata_i,
  output logic [`SOC_PAGES-1:0][`SOC_STRB_W-1:0] page_we_o,
  output logic [`SOC_PAGES-1:0]                 page_rd_o,
  output logic [`SOC_IDX_W-1:0]                 word_idx_o,
  output soc_pkg::bus_word_u                    wdata_o,
  output logic [`SOC_PSEL_W-1:0]                sel_page_o,
  output logic                                  done_o
);

  logic [`SOC_PSEL_W-1:0] page;

  assign page = req_addr_i[`SOC_OFS_W + `SOC_IDX_W +: `SOC_PSEL_W];

  // Strobes and done are one-cycle pulses
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      page_we_o <= '0;
      page_rd_o <= '0;
      done_o    <= 1'b0;
    end else begin
      page_we_o <= '0;
      page_rd_o <= '0;
      done_o    <= req_valid_i;
      if (req_valid_i) begin
        if (req_we_i) begin
          page_we_o[page] <= req_strb_i;
        end else begin
          page_rd_o[page] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      word_idx_o <= req_addr_i[`SOC_OFS_W +: `SOC_IDX_W];
      wdata_o    <= req_wdata_i;
      sel_page_o <= page;
    end
  end

endmodule

`default_nettype wire

//--- design/mem_page.sv
/*
 * One page of main memory, byte writable, synchronous read.
 * Contents are undefined after power up.
 */
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module mem_page (
  input  wire                      clk_i,
  input  wire [`SOC_STRB_W-1:0]    we_i,
  input  wire                      rd_i,
  input  wire [`SOC_IDX_W-1:0]     word_idx_i,
  input  wire soc_pkg::bus_word_u  wdata_i,
  output soc_pkg::bus_word_u       rdata_o
);

  import soc_pkg::*;

  bus_word_u mem [`SOC_PAGE_WORDS];

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `SOC_STRB_W; b++) begin
      if (we_i[b]) begin
        mem[word_idx_i].bytes[b] <= wdata_i.bytes[b];
      end
    end
  end

  // Output holds the last word read
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      rdata_o <= mem[word_idx_i];
    end
  end

endmodule

`default_nettype wire

//--- design/read_return.sv
/*
 * Return stage. Ack follows done by one edge and lasts one cycle.
 * Read data is valid only while ack is high.
 */
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module read_return (
  input  wire                                        clk_i,
  input  wire                                        rst_i,
  input  wire                                        done_i,
  input  wire [`SOC_PSEL_W-1:0]                      sel_page_i,
  input  wire soc_pkg::bus_word_u [`SOC_PAGES-1:0]   page_rdata_i,
  output logic                                       bus_ack_o,
  output soc_pkg::bus_word_u                         bus_rdata_o
);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus_ack_o <= 1'b0;
    end else begin
      bus_ack_o <= done_i;
    end
  end

  // Page output registers load at the same edge as ack
  // sel_page_i holds until the next request is registered
  assign bus_rdata_o = page_rdata_i[sel_page_i];

endmodule

`default_nettype wire

//--- design/soc_bus_top.sv
/*
 * Shared bus and main memory, two masters, no slave decode.
 * Ack comes SOC_ACK_LAT cycles after the grant, one access at a time.
 * Memory aliases every SOC_PAGES * SOC_PAGE_WORDS words.
 */
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_bus_top (
  input  wire                      clk_i,
  input  wire                      rst_i,
  // mmu master
  input  wire                      m_mmu_cyc_i,
  input  wire                      m_mmu_we_i,
  input  wire [`SOC_STRB_W-1:0]    m_mmu_strb_i,
  input  wire [`SOC_ADDR_W-1:0]    m_mmu_addr_i,
  input  wire [`SOC_DATA_W-1:0]    m_mmu_wdata_i,
  output logic                     m_mmu_ack_o,
  output logic [`SOC_DATA_W-1:0]   m_mmu_rdata_o,
  // dma master
  input  wire                      m_dma_cyc_i,
  input  wire                      m_dma_we_i,
  input  wire [`SOC_STRB_W-1:0]    m_dma_strb_i,
  input  wire [`SOC_ADDR_W-1:0]    m_dma_addr_i,
  input  wire [`SOC_DATA_W-1:0]    m_dma_wdata_i,
  output logic                     m_dma_ack_o,
  output logic [`SOC_DATA_W-1:0]   m_dma_rdata_o
);

  import soc_pkg::*;

  wire                                   req_valid;
  wire                                   req_we;
  wire [`SOC_STRB_W-1:0]                 req_strb;
  wire [`SOC_ADDR_W-1:0]                 req_addr;
  wire bus_word_u                        req_wdata;
  wire [`SOC_PAGES-1:0][`SOC_STRB_W-1:0] page_we;
  wire [`SOC_PAGES-1:0]                  page_rd;
  wire [`SOC_IDX_W-1:0]                  word_idx;
  wire bus_word_u                        page_wdata;
  wire [`SOC_PSEL_W-1:0]                 sel_page;
  wire                                   done;
  wire bus_word_u [`SOC_PAGES-1:0]       page_rdata;
  wire                                   bus_ack;
  wire bus_word_u                        bus_rdata;

  ////////////////////////////////////////
  // Arbiter
  ////////////////////////////////////////

  bus_arbiter u_bus_arbiter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .m_mmu_cyc_i   (m_mmu_cyc_i),
    .m_mmu_we_i    (m_mmu_we_i),
    .m_mmu_strb_i  (m_mmu_strb_i),
    .m_mmu_addr_i  (m_mmu_addr_i),
    .m_mmu_wdata_i (m_mmu_wdata_i),
    .m_mmu_ack_o   (m_mmu_ack_o),
    .m_mmu_rdata_o (m_mmu_rdata_o),
    .m_dma_cyc_i   (m_dma_cyc_i),
    .m_dma_we_i    (m_dma_we_i),
    .m_dma_strb_i  (m_dma_strb_i),
    .m_dma_addr_i  (m_dma_addr_i),
    .m_dma_wdata_i (m_dma_wdata_i),
    .m_dma_ack_o   (m_dma_ack_o),
    .m_dma_rdata_o (m_dma_rdata_o),
    .req_valid_o   (req_valid),
    .req_we_o      (req_we),
    .req_strb_o    (req_strb),
    .req_addr_o    (req_addr),
    .req_wdata_o   (req_wdata),
    .bus_ack_i     (bus_ack),
    .bus_rdata_i   (bus_rdata)
  );

  ////////////////////////////////////////
  // Main memory
  ////////////////////////////////////////

  page_select u_page_select (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_we_i    (req_we),
    .req_strb_i  (req_strb),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .page_we_o   (page_we),
    .page_rd_o   (page_rd),
    .word_idx_o  (word_idx),
    .wdata_o     (page_wdata),
    .sel_page_o  (sel_page),
    .done_o      (done)
  );

  for (genvar p = 0; p < `SOC_PAGES; p++) begin : g_page
    mem_page u_mem_page (
      .clk_i      (clk_i),
      .we_i       (page_we[p]),
      .rd_i       (page_rd[p]),
      .word_idx_i (word_idx),
      .wdata_i    (page_wdata),
      .rdata_o    (page_rdata[p])
    );
  end

  read_return u_read_return (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .done_i       (done),
    .sel_page_i   (sel_page),
    .page_rdata_i (page_rdata),
    .bus_ack_o    (bus_ack),
    .bus_rdata_o  (bus_rdata)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
/*
 * Testbench clock and reset, 100 ns period.
 * Reset is high from time 0 for 16 rising edges and drops on a falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD = 50;
  localparam int RST_CYCLES  = 16;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/soc_bus_chk.sv
/*
 * Handshake rules for both master ports, bound to every soc_bus_top.
 * Index 0 is the mmu port, index 1 the dma port.
 */
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_bus_chk (
  input wire                                             clk_i,
  input wire                                             rst_i,
  input wire [1:0]                                       cyc_i,
  input wire [1:0]                                       ack_i,
  input wire [`SOC_STRB_W+`SOC_ADDR_W+`SOC_DATA_W:0]     mmu_req_i,
  input wire [`SOC_STRB_W+`SOC_ADDR_W+`SOC_DATA_W:0]     dma_req_i
);

  int fail_cnt = 0;

  for (genvar m = 0; m < 2; m++) begin : g_master
    // Request fields frozen until ack
    a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      cyc_i[m] && !ack_i[m] |=> cyc_i[m] && $stable(m ? dma_req_i : mmu_req_i))
      else begin
        fail_cnt++;
        $error("master %0d dropped or changed its request before ack", m);
      end

    a_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      ack_i[m] |=> !ack_i[m])
      else begin
        fail_cnt++;
        $error("master %0d saw ack for more than one cycle", m);
      end

    a_ack_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      ack_i[m] |-> cyc_i[m])
      else begin
        fail_cnt++;
        $error("master %0d saw ack without cyc", m);
      end
  end

  a_rst_quiet: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> ack_i == 2'b00)
    else begin
      fail_cnt++;
      $error("ack raised during reset");
    end

endmodule

bind soc_bus_top soc_bus_chk u_soc_bus_chk (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .cyc_i     ({m_dma_cyc_i, m_mmu_cyc_i}),
  .ack_i     ({m_dma_ack_o, m_mmu_ack_o}),
  .mmu_req_i ({m_mmu_we_i, m_mmu_strb_i, m_mmu_addr_i, m_mmu_wdata_i}),
  .dma_req_i ({m_dma_we_i, m_dma_strb_i, m_dma_addr_i, m_dma_wdata_i})
);

`default_nettype wire

//--- testbench/tb_soc_bus.sv
/*
 * Testbench for soc_bus_top. Accesses come from testbench/bus_patterns.txt,
 * run from the project root. Inputs change on the falling clock edge.
 * A pair record drives mmu and dma in the same cycle, mmu line first.
 */
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module tb_soc_bus;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 16;
  localparam int MAX_GAP    = 3;
  localparam int MAX_LINES  = 64;
  localparam int REC_W      = 7;

  wire                                  clk;
  wire                                  rst;
  // Index 0 is mmu and index 1 is dma
  logic [1:0]                           cyc;
  logic [1:0]                           we;
  logic [1:0][`SOC_STRB_W-1:0]          strb;
  logic [1:0][`SOC_ADDR_W-1:0]          addr;
  logic [1:0][`SOC_DATA_W-1:0]          wdata;
  wire  [1:0]                           ack;
  wire  [1:0][`SOC_DATA_W-1:0]          rdata;

  logic [31:0] pat_mem [MAX_LINES*REC_W];
  int          n_lines;
  int          n_tests;
  int          n_checks;
  int          n_errors;
  logic        loaded;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  soc_bus_top u_dut (
    .clk_i         (clk),
    .rst_i         (rst),
    .m_mmu_cyc_i   (cyc[0]),
    .m_mmu_we_i    (we[0]),
    .m_mmu_strb_i  (strb[0]),
    .m_mmu_addr_i  (addr[0]),
    .m_mmu_wdata_i (wdata[0]),
    .m_mmu_ack_o   (ack[0]),
    .m_mmu_rdata_o (rdata[0]),
    .m_dma_cyc_i   (cyc[1]),
    .m_dma_we_i    (we[1]),
    .m_dma_strb_i  (strb[1]),
    .m_dma_addr_i  (addr[1]),
    .m_dma_wdata_i (wdata[1]),
    .m_dma_ack_o   (ack[1]),
    .m_dma_rdata_o (rdata[1])
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t ns",
               name, actual, expected, $time);
    end
  endtask

  task automatic report_test(input string what, input int errs_before);
    n_tests++;
    $display("test %0d %s: %s", n_tests, what,
             (n_errors == errs_before) ? "ok" : "FAILED");
  endtask

  // Runs one pattern record between two falling edges
  task automatic run_access(input int rec, input bit paired);
    int          base;
    int          lat;
    int          exp_lat;
    int unsigned m;
    string       who;
    base = rec * REC_W;
    m    = pat_mem[base+1][0];
    who  = m ? "m_dma" : "m_mmu";
    // Idle bus grants at the next edge and acks SOC_ACK_LAT edges later
    exp_lat = `SOC_ACK_LAT + 1;
    // Losing master waits for the winner's ack edge before its grant
    if (paired && m == 1) begin
      exp_lat = 2 * (`SOC_ACK_LAT + 1);
    end
    we[m]    = pat_mem[base+2][0];
    strb[m]  = pat_mem[base+3][`SOC_STRB_W-1:0];
    addr[m]  = pat_mem[base+4];
    wdata[m] = pat_mem[base+5];
    cyc[m]   = 1'b1;
    lat = 0;
    while (!ack[m]) begin
      @(negedge clk);
      lat++;
    end
    check_value({who, "_ack_o latency"}, lat, exp_lat);
    if (!we[m]) begin
      check_value({who, "_rdata_o"}, rdata[m], pat_mem[base+6]);
    end
    @(negedge clk);
    cyc[m]   = 1'b0;
    we[m]    = 1'b0;
    strb[m]  = '0;
    addr[m]  = '0;
    wdata[m] = '0;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int          idx;
    int          errs_before;
    int unsigned gap;
    int unsigned seed_ret;
    cyc      = '0;
    we       = '0;
    strb     = '0;
    addr     = '0;
    wdata    = '0;
    n_tests  = 0;
    n_checks = 0;
    n_errors = 0;
    loaded   = 1'b0;
    seed_ret = $urandom(32'hb32a);
    // Fill with the end marker so a short or missing file stops the count
    for (int i = 0; i < MAX_LINES * REC_W; i++) begin
      pat_mem[i] = 32'hf;
    end
    $readmemh("testbench/bus_patterns.txt", pat_mem);
    n_lines = 0;
    while (n_lines < MAX_LINES && pat_mem[n_lines*REC_W] != 32'hf) begin
      n_lines++;
    end
    loaded = 1'b1;

    if (n_lines == 0) begin
      $display("No accesses could be read from testbench/bus_patterns.txt");
      n_errors++;
    end else begin
      errs_before = n_errors;
      // Ack is unknown until the first clock edge
      @(posedge clk);
      repeat (RST_CYCLES) begin
        @(negedge clk);
        check_value("m_mmu_ack_o", ack[0], 1'b0);
        check_value("m_dma_ack_o", ack[1], 1'b0);
      end
      wait (rst == 1'b0);
      repeat (2) begin
        @(negedge clk);
        check_value("m_mmu_ack_o", ack[0], 1'b0);
        check_value("m_dma_ack_o", ack[1], 1'b0);
      end
      report_test("reset, both acks low", errs_before);

      idx = 0;
      while (idx < n_lines) begin
        errs_before = n_errors;
        if (pat_mem[idx*REC_W] == 32'h1 && idx + 1 < n_lines) begin
          fork
            run_access(idx, 1'b1);
            run_access(idx + 1, 1'b1);
          join
          report_test($sformatf("lines %0d-%0d, both masters", idx + 1, idx + 2),
                      errs_before);
          idx += 2;
        end else begin
          run_access(idx, 1'b0);
          report_test($sformatf("line %0d, %s %s 0x%08h", idx + 1,
                                pat_mem[idx*REC_W+1][0] ? "dma" : "mmu",
                                pat_mem[idx*REC_W+2][0] ? "write" : "read",
                                pat_mem[idx*REC_W+4]), errs_before);
          idx += 1;
        end
        gap = $urandom_range(MAX_GAP, 0);
        repeat (gap) @(negedge clk);
      end
    end

    if (u_dut.u_soc_bus_chk.fail_cnt != 0) begin
      $display("Bus protocol assertions failed %0d times", u_dut.u_soc_bus_chk.fail_cnt);
      n_errors += u_dut.u_soc_bus_chk.fail_cnt;
    end
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial begin
    int limit;
    wait (loaded);
    limit = RST_CYCLES + 4 + n_lines * (`SOC_ACK_LAT + MAX_GAP + 4);
    #(limit * CLK_PERIOD);
    $display("Run stopped after %0d clock cycles, a master never got its ack", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/bus_patterns.txt
// kind (0 single, 1 pair, f end) master (0 mmu, 1 dma) we strb addr wdata expected
// Pair: two lines marked 1 run together, mmu line first; expected is checked on reads
// Full-word write and read back
0 0 1 f 00000010 a5a51234 00000000
0 0 0 f 00000010 00000000 a5a51234
0 1 1 f 00000020 0badf00d 00000000
0 1 0 f 00000020 00000000 0badf00d
// Byte strobes
0 0 1 f 00000100 11223344 00000000
0 0 1 1 00000100 aabbccdd 00000000
0 0 0 f 00000100 00000000 112233dd
0 1 1 6 00000100 eeff0099 00000000
0 1 0 f 00000100 00000000 11ff00dd
0 0 1 8 00000100 77000000 00000000
0 1 1 0 00000100 ffffffff 00000000
0 0 0 f 00000100 00000000 77ff00dd
// Same word index in pages 0, 1 and 7
0 0 1 f 00000040 10000000 00000000
0 0 1 f 00001040 10000001 00000000
0 1 1 f 00007040 10000007 00000000
0 0 0 f 00000040 00000000 10000000
0 1 0 f 00001040 00000000 10000001
0 0 0 f 00007040 00000000 10000007
// Last word of page 2, first of page 3
0 0 1 f 00002ffc cafe2ffc 00000000
0 1 1 f 00003000 beef3000 00000000
0 0 0 f 00002ffc 00000000 cafe2ffc
0 1 0 f 00003000 00000000 beef3000
// Aliasing above 32 KiB
0 0 0 f 00008010 00000000 a5a51234
0 1 0 f fff87040 00000000 10000007
0 1 1 f 12345100 5a5a0001 00000000
0 0 0 f 00005100 00000000 5a5a0001
// Contention
1 0 1 f 00000200 aaaa0200 00000000
1 1 1 f 00000204 bbbb0204 00000000
1 0 0 f 00000204 00000000 bbbb0204
1 1 0 f 00000200 00000000 aaaa0200
1 0 1 f 00000300 11110300 00000000
1 1 1 f 00000300 22220300 00000000
0 0 0 f 00000300 00000000 22220300
f 0 0 0 00000000 00000000 00000000

//--- all.f
+incdir+design
design/soc_pkg.sv
design/bus_arbiter.sv
design/page_select.sv
design/mem_page.sv
design/read_return.sv
design/soc_bus_top.sv
testbench/tb_clk_gen.sv
testbench/soc_bus_chk.sv
testbench/tb_soc_bus.sv

//--- Bender.yml
package:
  name: soc_bus

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/soc_pkg.sv
      - design/bus_arbiter.sv
      - design/page_select.sv
      - design/mem_page.sv
      - design/read_return.sv
      - design/soc_bus_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clk_gen.sv
      - testbench/soc_bus_chk.sv
      - testbench/tb_soc_bus.sv
